// File: build.f
+incdir+.
frame_buffer_pkg.sv
duram.sv
frame_write_ctrl.sv
frame_read_ctrl.sv
frame_buffer.sv
frame_buffer_tb.sv

// File: duram.sv
module duram
#(
    parameter int DATA_WIDTH = 9,
    parameter int ADDR_WIDTH = 6
)
(
    input  logic                  clock_a,
    input  logic                  clock_b,
    input  logic                  wren_a,
    input  logic [ADDR_WIDTH-1:0] address_a,
    input  logic [DATA_WIDTH-1:0] data_a,
    input  logic [ADDR_WIDTH-1:0] address_b,
    output logic [DATA_WIDTH-1:0] q_b
);

    localparam int depth = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [depth];

    // Port A is write only.
    always_ff @(posedge clock_a)
    begin
        if (wren_a)
        begin
            mem[address_a] <= data_a;
        end
    end

    // Port B is read only; a colliding write is seen on the next read.
    always_ff @(posedge clock_b)
    begin
        q_b <= mem[address_b];
    end

    wr_addr_known: assert property (@(posedge clock_a) wren_a |-> !$isunknown(address_a))
        else $error("duram: write with unknown address_a");

endmodule

// File: frame_buffer.sv
module frame_buffer
#(
    parameter int ADDR_WIDTH    = 6,
    parameter int MAX_FRAME_LEN = 24,
    parameter int MIN_FRAME_LEN = 4
)
(
    input  logic                                 clock_a,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  logic                                 in_sop,
    input  logic                                 in_eop,
    input  logic                                 in_err,
    input  logic [frame_buffer_pkg::byte_w-1:0]  in_data,
    output logic                                 out_valid,
    output logic                                 out_sop,
    output logic                                 out_eop,
    output logic [frame_buffer_pkg::byte_w-1:0]  out_data,
    output logic                                 drop_valid,
    output frame_buffer_pkg::drop_cause_t        drop_cause
);

    import frame_buffer_pkg::*;

    logic                  ram_wr_en;
    logic [ADDR_WIDTH-1:0] ram_wr_addr;
    logic [word_w-1:0]     ram_wr_word;
    logic [ADDR_WIDTH-1:0] ram_rd_addr;
    logic [word_w-1:0]     ram_rd_word;
    logic                  frame_commit;

    // One frame draining and one filling must fit, so the buffer never overflows.
    if (2 ** ADDR_WIDTH < 2 * MAX_FRAME_LEN + 2)
    begin : g_depth_check
        $fatal(1, "frame_buffer: RAM depth too small for MAX_FRAME_LEN");
    end

    if (MIN_FRAME_LEN < 1 || MIN_FRAME_LEN > MAX_FRAME_LEN)
    begin : g_min_check
        $fatal(1, "frame_buffer: MIN_FRAME_LEN out of range");
    end

    if (MAX_FRAME_LEN >= 2 ** len_w - 1)
    begin : g_len_check
        $fatal(1, "frame_buffer: MAX_FRAME_LEN does not fit the length counter");
    end

    frame_write_ctrl
    #(
        .ADDR_WIDTH    (ADDR_WIDTH),
        .MAX_FRAME_LEN (MAX_FRAME_LEN),
        .MIN_FRAME_LEN (MIN_FRAME_LEN)
    )
    frame_write_ctrl_inst
    (
        .clock_a      (clock_a),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_sop       (in_sop),
        .in_eop       (in_eop),
        .in_err       (in_err),
        .in_data      (in_data),
        .ram_wr_en    (ram_wr_en),
        .ram_wr_addr  (ram_wr_addr),
        .ram_wr_word  (ram_wr_word),
        .frame_commit (frame_commit),
        .drop_valid   (drop_valid),
        .drop_cause   (drop_cause)
    );

    duram
    #(
        .DATA_WIDTH (word_w),
        .ADDR_WIDTH (ADDR_WIDTH)
    )
    duram_inst
    (
        .clock_a   (clock_a),
        .clock_b   (clock_a), // Single clock domain.
        .wren_a    (ram_wr_en),
        .address_a (ram_wr_addr),
        .data_a    (ram_wr_word),
        .address_b (ram_rd_addr),
        .q_b       (ram_rd_word)
    );

    frame_read_ctrl
    #(
        .ADDR_WIDTH (ADDR_WIDTH)
    )
    frame_read_ctrl_inst
    (
        .clock_a      (clock_a),
        .rst_n        (rst_n),
        .frame_commit (frame_commit),
        .ram_rd_word  (ram_rd_word),
        .ram_rd_addr  (ram_rd_addr),
        .out_valid    (out_valid),
        .out_sop      (out_sop),
        .out_eop      (out_eop),
        .out_data     (out_data)
    );

endmodule

// File: frame_buffer_pkg.sv
package frame_buffer_pkg;

    // Payload byte width.
    localparam int byte_w = 8;

    // RAM word: the payload byte in the low bits, the last flag on top.
    localparam int word_w = byte_w + 1;
    localparam int word_last_bit = word_w - 1;

    // Frame length counters saturate one above the longest legal frame.
    localparam int len_w = 8;

    typedef enum logic [1:0]
    {
        drop_err   = 2'd0, // Error flag set on the eop byte.
        drop_long  = 2'd1, // More bytes than the maximum frame length.
        drop_short = 2'd2  // Fewer bytes than the minimum frame length.
    } drop_cause_t;

endpackage

// File: frame_buffer_tb_vectors.svh
`ifndef FRAME_BUFFER_TB_VECTORS_SVH
`define FRAME_BUFFER_TB_VECTORS_SVH

// Columns: frame length in bytes, error flag on the eop byte, idle cycles before the frame.
typedef struct packed
{
    logic [7:0] len;
    logic       err;
    logic [7:0] gap;
} frame_entry_t;

localparam int num_frames = 32;

localparam frame_entry_t frame_table [num_frames] = '{
    '{8'd4,  1'b0, 8'd3}, // Shortest frame that is kept.
    '{8'd24, 1'b0, 8'd0}, // Longest frame that is kept.
    '{8'd10, 1'b0, 8'd0},
    '{8'd17, 1'b0, 8'd2},
    '{8'd5,  1'b1, 8'd2},
    '{8'd30, 1'b1, 8'd1}, // Error wins over too long.
    '{8'd2,  1'b1, 8'd0}, // Error wins over too short.
    '{8'd25, 1'b0, 8'd3},
    '{8'd40, 1'b0, 8'd2},
    '{8'd1,  1'b0, 8'd2}, // Single byte, sop and eop together.
    '{8'd3,  1'b0, 8'd0},
    '{8'd12, 1'b0, 8'd4},
    '{8'd24, 1'b0, 8'd0},
    '{8'd8,  1'b0, 8'd0},
    '{8'd20, 1'b0, 8'd1},
    '{8'd16, 1'b1, 8'd3},
    '{8'd6,  1'b0, 8'd0},
    '{8'd23, 1'b0, 8'd2},
    '{8'd26, 1'b0, 8'd1},
    '{8'd9,  1'b0, 8'd0},
    '{8'd15, 1'b0, 8'd5},
    '{8'd2,  1'b0, 8'd1},
    '{8'd19, 1'b0, 8'd0},
    '{8'd7,  1'b1, 8'd2},
    '{8'd24, 1'b0, 8'd1},
    '{8'd11, 1'b0, 8'd0},
    '{8'd4,  1'b0, 8'd2},
    '{8'd13, 1'b0, 8'd3},
    '{8'd21, 1'b0, 8'd0},
    '{8'd1,  1'b1, 8'd2},
    '{8'd18, 1'b0, 8'd1},
    '{8'd5,  1'b0, 8'd0}
};

// A frame is kept only without error and with a length inside the legal range.
function automatic bit frame_is_kept(input int len, input bit err);
    return !err && len >= min_frame_len && len <= max_frame_len;
endfunction

function automatic drop_cause_t expected_cause(input int len, input bit err);
    drop_cause_t cause;
    if (err)
    begin
        cause = drop_err;
    end
    else if (len > max_frame_len)
    begin
        cause = drop_long;
    end
    else
    begin
        cause = drop_short;
    end
    return cause;
endfunction

`endif

// File: frame_buffer_tb.sv
module frame_buffer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import frame_buffer_pkg::*;

    localparam int addr_width    = 6;
    localparam int max_frame_len = 24;
    localparam int min_frame_len = 4;

    `include "frame_buffer_tb_vectors.svh"

    logic              clock_a;
    logic              rst_n;
    logic              in_valid;
    logic              in_sop;
    logic              in_eop;
    logic              in_err;
    logic [byte_w-1:0] in_data;
    logic              out_valid;
    logic              out_sop;
    logic              out_eop;
    logic [byte_w-1:0] out_data;
    logic              drop_valid;
    drop_cause_t       drop_cause;

    int                seed;
    logic [byte_w+1:0] byte_q [$]; // Expected {sop, eop, data} of kept frames.
    drop_cause_t       drop_q [$];

    frame_buffer
    #(
        .ADDR_WIDTH    (addr_width),
        .MAX_FRAME_LEN (max_frame_len),
        .MIN_FRAME_LEN (min_frame_len)
    )
    frame_buffer_inst
    (
        .clock_a    (clock_a),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_sop     (in_sop),
        .in_eop     (in_eop),
        .in_err     (in_err),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_sop    (out_sop),
        .out_eop    (out_eop),
        .out_data   (out_data),
        .drop_valid (drop_valid),
        .drop_cause (drop_cause)
    );

    initial
    begin
        clock_a = 1'b0;
        forever #5 clock_a = ~clock_a;
    end

    task automatic end_in_failure();
        $display(">>> FAIL");
        $fatal(1, "Testbench stopped at the first error.");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            end_in_failure();
        end
    endtask

    task automatic drive_idle(input int cycles);
        int c;
        for (c = 0; c < cycles; c++)
        begin
            @(negedge clock_a);
            in_valid = 1'b0;
            in_sop   = 1'b0;
            in_eop   = 1'b0;
            in_err   = 1'b0;
            in_data  = '0;
        end
    endtask

    task automatic drive_frame(input int len, input bit err);
        int                b;
        int                rnd;
        logic [byte_w-1:0] value;
        bit                kept;
        kept = frame_is_kept(len, err);
        if (!kept)
        begin
            drop_q.push_back(expected_cause(len, err));
        end
        for (b = 0; b < len; b++)
        begin
            rnd   = $random(seed);
            value = rnd[byte_w-1:0];
            @(negedge clock_a);
            in_valid = 1'b1;
            in_sop   = (b == 0);
            in_eop   = (b == len - 1);
            in_err   = err && (b == len - 1); // The flag only counts on the eop byte.
            in_data  = value;
            if (kept)
            begin
                byte_q.push_back({in_sop, in_eop, value});
            end
        end
    endtask

    // Outputs come from registers, so they are stable at the falling edge.
    initial
    begin : output_monitor
        logic [byte_w+1:0] expected_byte;
        forever
        begin
            @(negedge clock_a);
            if (rst_n === 1'b1 && $isunknown({out_valid, drop_valid}))
            begin
                $display("Output valid or drop valid is unknown after reset.");
                end_in_failure();
            end
            if (out_valid === 1'b1)
            begin
                if (byte_q.size() == 0)
                begin
                    $display("Output byte 0x%0h appeared with no kept frame waiting.", out_data);
                    end_in_failure();
                end
                else
                begin
                    expected_byte = byte_q.pop_front();
                    compare_value("out_data", 32'(out_data), 32'(expected_byte[byte_w-1:0]));
                    compare_value("out_sop", 32'(out_sop), 32'(expected_byte[byte_w+1]));
                    compare_value("out_eop", 32'(out_eop), 32'(expected_byte[byte_w]));
                end
            end
        end
    end

    initial
    begin : drop_monitor
        drop_cause_t expected_drop;
        forever
        begin
            @(negedge clock_a);
            if (drop_valid === 1'b1)
            begin
                if (drop_q.size() == 0)
                begin
                    $display("A drop was reported although no frame was due to be dropped.");
                    end_in_failure();
                end
                else
                begin
                    expected_drop = drop_q.pop_front();
                    compare_value("drop_cause", 32'(drop_cause), 32'(expected_drop));
                end
            end
        end
    end

    initial
    begin : watchdog
        int budget;
        int i;
        budget = 200;
        for (i = 0; i < num_frames; i++)
        begin
            budget += 2 * (int'(frame_table[i].len) + int'(frame_table[i].gap));
        end
        repeat (budget) @(posedge clock_a);
        $display("Watchdog expired after %0d cycles before all frames were seen.", budget);
        end_in_failure();
    end

    initial
    begin : stimulus
        int i;
        seed     = 32'h862d_ef64;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        in_err   = 1'b0;
        in_data  = '0;
        repeat (2) @(negedge clock_a);
        rst_n = 1'b1;
        compare_value("out_valid", 32'(out_valid), 32'h0);
        compare_value("drop_valid", 32'(drop_valid), 32'h0);

        for (i = 0; i < num_frames; i++)
        begin
            drive_idle(int'(frame_table[i].gap));
            drive_frame(int'(frame_table[i].len), frame_table[i].err);
        end
        drive_idle(1);

        while (byte_q.size() != 0 || drop_q.size() != 0)
        begin
            @(negedge clock_a);
        end
        repeat (20) @(negedge clock_a); // Any late output here is caught by the monitors.

        if (out_valid !== 1'b0 || drop_valid !== 1'b0)
        begin
            $display("The DUT was still sending after every expected frame had been seen.");
            end_in_failure();
        end
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: frame_read_ctrl.sv
module frame_read_ctrl
#(
    parameter int ADDR_WIDTH = 6
)
(
    input  logic                                 clock_a,
    input  logic                                 rst_n,
    input  logic                                 frame_commit,
    input  logic [frame_buffer_pkg::word_w-1:0]  ram_rd_word,
    output logic [ADDR_WIDTH-1:0]                ram_rd_addr,
    output logic                                 out_valid,
    output logic                                 out_sop,
    output logic                                 out_eop,
    output logic [frame_buffer_pkg::byte_w-1:0]  out_data
);

    import frame_buffer_pkg::*;

    logic [ADDR_WIDTH:0]   pend_cnt; // Committed frames not yet fully sent.
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic                  rd_inflight;
    logic                  first_byte;

    logic                  rd_issue;
    logic                  word_last;

    always_comb
    begin
        rd_issue    = pend_cnt != '0;
        word_last   = rd_inflight && ram_rd_word[word_last_bit];
        ram_rd_addr = rd_ptr;
        out_valid   = rd_inflight;
        out_sop     = rd_inflight && first_byte;
        out_eop     = word_last;
        out_data    = ram_rd_word[byte_w-1:0];
    end

    always_ff @(posedge clock_a or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend_cnt    <= '0;
            rd_ptr      <= '0;
            rd_inflight <= 1'b0;
            first_byte  <= 1'b1;
        end
        else
        begin
            case ({frame_commit, word_last})
                2'b10:   pend_cnt <= pend_cnt + 1'b1;
                2'b01:   pend_cnt <= pend_cnt - 1'b1;
                default: pend_cnt <= pend_cnt;
            endcase

            if (word_last)
            begin
                // rd_ptr already points past the last word; hold it there.
                // The read issued this cycle is the over-read and gets dropped.
                rd_inflight <= 1'b0;
                first_byte  <= 1'b1;
            end
            else
            begin
                rd_inflight <= rd_issue;
                if (rd_issue)
                begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                if (rd_inflight)
                begin
                    first_byte <= 1'b0;
                end
            end
        end
    end

    pend_no_underflow: assert property (@(posedge clock_a) disable iff (!rst_n)
        out_eop |-> pend_cnt != '0)
        else $error("frame_read_ctrl: frame sent without a pending commit");

endmodule

// File: frame_write_ctrl.sv
module frame_write_ctrl
#(
    parameter int ADDR_WIDTH    = 6,
    parameter int MAX_FRAME_LEN = 24,
    parameter int MIN_FRAME_LEN = 4
)
(
    input  logic                                 clock_a,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  logic                                 in_sop,
    input  logic                                 in_eop,
    input  logic                                 in_err,
    input  logic [frame_buffer_pkg::byte_w-1:0]  in_data,
    output logic                                 ram_wr_en,
    output logic [ADDR_WIDTH-1:0]                ram_wr_addr,
    output logic [frame_buffer_pkg::word_w-1:0]  ram_wr_word,
    output logic                                 frame_commit,
    output logic                                 drop_valid,
    output frame_buffer_pkg::drop_cause_t        drop_cause
);

    import frame_buffer_pkg::*;

    localparam logic [len_w-1:0] max_len = len_w'(MAX_FRAME_LEN);
    localparam logic [len_w-1:0] min_len = len_w'(MIN_FRAME_LEN);

    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] frame_base; // Start of the open frame, also the commit base.
    logic [len_w-1:0]      frame_len;
    logic                  frame_open;

    logic                  accept;
    logic [len_w-1:0]      cur_len;
    logic                  frame_end;
    logic                  len_over;
    logic                  len_under;
    logic                  keep;
    drop_cause_t           cause_next;

    always_comb
    begin
        accept = in_valid && (in_sop || frame_open); // Stray bytes outside a frame are ignored.

        // Length including the current byte, saturating at max_len + 1.
        if (in_sop)
        begin
            cur_len = len_w'(1);
        end
        else if (frame_len > max_len)
        begin
            cur_len = frame_len;
        end
        else
        begin
            cur_len = frame_len + 1'b1;
        end

        frame_end = accept && in_eop;
        len_over  = cur_len > max_len;
        len_under = cur_len < min_len;
        keep      = !in_err && !len_over && !len_under;

        if (in_err)
        begin
            cause_next = drop_err;
        end
        else if (len_over)
        begin
            cause_next = drop_long;
        end
        else
        begin
            cause_next = drop_short;
        end

        // A new sop restarts at the commit base, which discards an abandoned frame.
        ram_wr_en   = accept && !len_over;
        ram_wr_addr = in_sop ? frame_base : wr_ptr;
        ram_wr_word = {in_eop, in_data};
    end

    always_ff @(posedge clock_a or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr       <= '0;
            frame_base   <= '0;
            frame_len    <= '0;
            frame_open   <= 1'b0;
            frame_commit <= 1'b0;
            drop_valid   <= 1'b0;
        end
        else
        begin
            frame_commit <= frame_end && keep;
            drop_valid   <= frame_end && !keep;

            if (frame_end)
            begin
                frame_open <= 1'b0;
                frame_len  <= '0;
                if (keep)
                begin
                    wr_ptr     <= ram_wr_addr + 1'b1; // Commit base moves past the eop byte.
                    frame_base <= ram_wr_addr + 1'b1;
                end
                else
                begin
                    wr_ptr <= frame_base; // Rewind over the dropped frame.
                end
            end
            else if (accept)
            begin
                frame_open <= 1'b1;
                frame_len  <= cur_len;
                if (ram_wr_en)
                begin
                    wr_ptr <= ram_wr_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock_a)
    begin
        if (frame_end)
        begin
            drop_cause <= cause_next;
        end
    end

    no_write_past_max: assert property (@(posedge clock_a) disable iff (!rst_n)
        ram_wr_en |-> ram_wr_addr - frame_base < ADDR_WIDTH'(MAX_FRAME_LEN))
        else $error("frame_write_ctrl: byte written beyond MAX_FRAME_LEN");

    commit_drop_exclusive: assert property (@(posedge clock_a) disable iff (!rst_n)
        !(frame_commit && drop_valid))
        else $error("frame_write_ctrl: commit and drop in the same cycle");

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile the frame buffer testbench with Verilator, run it and check the log.

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module frame_buffer_tb -f build.f -o frame_buffer_sim \
    && ./obj_dir/frame_buffer_sim > sim.log 2>&1 \
    || echo "Build or simulation exited with an error."

cat sim.log 2>/dev/null

grep -q '>>> PASS' sim.log && echo "Simulation passed." \
    || { echo "Simulation failed."; exit 1; }
